//--- Makefile
# Verilator flow for the issue stage
FLIST = issue_stage.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module is_tb -f $(FLIST)

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module is_tb -Mdir obj_dir -f $(FLIST)
	@out="$$(./obj_dir/Vis_tb)"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- issue_stage.f
verilog/is_cfg_pkg.sv
verilog/is_inst_pkg.sv
verilog/isq_if.sv
verilog/is_queue.sv
verilog/is_wakeup.sv
verilog/is_select.sv
verilog/is_top.sv
verif/is_tb.sv

//--- verif/is_tb.sv
// testbench for the issue stage top, random instructions from an LFSR
// a cycle model of the eight slots predicts full and every port each edge
`default_nettype none

module is_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import is_cfg_pkg::*;
   import is_inst_pkg::*;

   localparam int WAIT_MAX = 40;

   logic                clk;
   logic                rst_n;
   logic                alloc_vld;
   alloc_t              alloc;
   logic                flush;
   bcast_t              bcast [NUM_BCAST];
   logic [NUM_PORT-1:0] fu_rdy;
   wire logic           full;
   wire logic           got_vld [NUM_PORT];
   wire issue_t         got_iss [NUM_PORT];

   // model state, one entry per slot
   logic   m_vld [ISQ_DEPTH];
   logic   m_r1 [ISQ_DEPTH];
   logic   m_r2 [ISQ_DEPTH];
   alloc_t m_ent [ISQ_DEPTH];
   logic   exp_vld [NUM_PORT];
   issue_t exp_iss [NUM_PORT];
   logic   exp_full;
   logic   started;

   logic [15:0] lfsr_q;
   int          errors;
   int          checks;
   int          pushed;
   int          issued;
   int          test_no;
   int          tests_failed;
   int          err_base;

   is_top dut (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .alloc_vld_i (alloc_vld),
      .alloc_i     (alloc),
      .full_o      (full),
      .flush_i     (flush),
      .bcast_i     (bcast),
      .fu_rdy_i    (fu_rdy),
      .mul_vld_o   (got_vld[PORT_MUL]),
      .mul_iss_o   (got_iss[PORT_MUL]),
      .alu0_vld_o  (got_vld[PORT_ALU0]),
      .alu0_iss_o  (got_iss[PORT_ALU0]),
      .alu1_vld_o  (got_vld[PORT_ALU1]),
      .alu1_iss_o  (got_iss[PORT_ALU1]),
      .adr_vld_o   (got_vld[PORT_ADR]),
      .adr_iss_o   (got_iss[PORT_ADR])
   );

   always #50 clk = ~clk;

   ////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////

   // fibonacci lfsr, taps 16 14 13 11, one step per bit
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      logic        fb;
      v = '0;
      for (int k = 0; k < n; k++)
      begin
         fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         v = {v[14:0], fb};
      end
      return v;
   endfunction

   function automatic fu_class_e rand_class();
      logic [15:0] v;
      v = rand_bits(2);
      case (v[1:0])
         2'd0: return FU_MUL;
         2'd2: return FU_ADR;
         default: return FU_ALU;
      endcase
   endfunction

   function automatic alloc_t make_inst(input fu_class_e cls, input logic r1, input logic r2);
      alloc_t a;
      a.fu_class  = cls;
      a.op        = op_t'(rand_bits(4));
      a.pdest     = preg_t'(rand_bits(PREG_W));
      a.psrc1     = preg_t'(rand_bits(PREG_W));
      a.psrc1_rdy = r1;
      a.psrc2     = preg_t'(rand_bits(PREG_W));
      a.psrc2_rdy = r2;
      return a;
   endfunction

   function automatic int port_of(input fu_class_e cls);
      case (cls)
         FU_MUL: return PORT_MUL;
         FU_ADR: return PORT_ADR;
         default: return PORT_ALU0;
      endcase
   endfunction

   function automatic string port_name(input int p);
      case (p)
         PORT_MUL: return "mul";
         PORT_ALU0: return "alu0";
         PORT_ALU1: return "alu1";
         default: return "adr";
      endcase
   endfunction

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic idle(input int n);
      repeat (n) tick();
   endtask

   task automatic note_error(input string msg);
      $display("%s", msg);
      errors++;
   endtask

   // holds the instruction while full, accepted at the next free edge
   task automatic push(input alloc_t a);
      int n;
      alloc_vld = 1'b1;
      alloc = a;
      n = 0;
      while (full && n < WAIT_MAX)
      begin
         tick();
         n++;
      end
      if (full)
         note_error("allocation stayed blocked by full_o");
      else
      begin
         tick();
         pushed++;
      end
      alloc_vld = 1'b0;
   endtask

   // entry must issue exactly one edge after it became ready
   task automatic expect_issue(input int p);
      int n;
      n = 0;
      do
      begin
         tick();
         n++;
      end
      while (got_vld[p] !== 1'b1 && n < WAIT_MAX);
      if (got_vld[p] !== 1'b1)
         note_error($sformatf("no issue on port %s before timeout", port_name(p)));
      else if (n != 1)
         note_error($sformatf("port %s issued %0d edges late", port_name(p), n - 1));
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (issued != pushed && n < WAIT_MAX)
      begin
         tick();
         n++;
      end
      if (issued != pushed)
         note_error($sformatf("queue did not drain, %0d of %0d issued", issued, pushed));
   endtask

   task automatic report_test(input string name);
      int errs;
      errs = errors - err_base;
      test_no++;
      $display("test %0d %s: %0d errors", test_no, name, errs);
      if (errs != 0)
         tests_failed++;
      err_base = errors;
   endtask

   ////////////////////////////////////////
   // reference model and compare
   ////////////////////////////////////////

   function automatic logic bus_hit(input preg_t tag);
      logic hit;
      hit = 1'b0;
      for (int b = 0; b < NUM_BCAST; b++)
      begin
         if (bcast[b][PREG_W] && bcast[b][PREG_W-1:0] == tag)
            hit = 1'b1;
      end
      return hit;
   endfunction

   // one clock edge of the queue, predicts the registered outputs
   function automatic void model_step();
      int   sel [NUM_PORT];
      int   slot;
      logic was_full;
      was_full = 1'b1;
      slot = -1;
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         if (!rst_n)
            m_vld[i] = 1'b0;
         if (!m_vld[i])
            was_full = 1'b0;
         if (!m_vld[i] && slot < 0)
            slot = i;
      end
      for (int p = 0; p < NUM_PORT; p++)
      begin
         sel[p] = -1;
         exp_vld[p] = 1'b0;
      end
      // lowest ready slot per class, alu 1 gets the second one
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         if (m_vld[i] && m_r1[i] && m_r2[i])
         begin
            if (m_ent[i].fu_class == FU_MUL && sel[PORT_MUL] < 0)
               sel[PORT_MUL] = i;
            else if (m_ent[i].fu_class == FU_ADR && sel[PORT_ADR] < 0)
               sel[PORT_ADR] = i;
            else if (m_ent[i].fu_class == FU_ALU && sel[PORT_ALU0] < 0)
               sel[PORT_ALU0] = i;
            else if (m_ent[i].fu_class == FU_ALU && sel[PORT_ALU1] < 0)
               sel[PORT_ALU1] = i;
         end
      end
      for (int p = 0; p < NUM_PORT; p++)
      begin
         if (rst_n && !flush && fu_rdy[p] && sel[p] >= 0)
         begin
            exp_vld[p] = 1'b1;
            exp_iss[p].op = m_ent[sel[p]].op;
            exp_iss[p].pdest = m_ent[sel[p]].pdest;
            exp_iss[p].psrc1 = m_ent[sel[p]].psrc1;
            exp_iss[p].psrc2 = m_ent[sel[p]].psrc2;
         end
      end
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         m_r1[i] = m_r1[i] | bus_hit(m_ent[i].psrc1);
         m_r2[i] = m_r2[i] | bus_hit(m_ent[i].psrc2);
      end
      for (int p = 0; p < NUM_PORT; p++)
      begin
         if (exp_vld[p])
            m_vld[sel[p]] = 1'b0;
      end
      if (flush)
      begin
         for (int i = 0; i < ISQ_DEPTH; i++)
            m_vld[i] = 1'b0;
      end
      else if (rst_n && alloc_vld && !was_full)
      begin
         m_vld[slot] = 1'b1;
         m_ent[slot] = alloc;
         m_r1[slot] = alloc.psrc1_rdy | bus_hit(alloc.psrc1);
         m_r2[slot] = alloc.psrc2_rdy | bus_hit(alloc.psrc2);
      end
      exp_full = 1'b1;
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         if (!m_vld[i])
            exp_full = 1'b0;
      end
   endfunction

   task automatic check_issue(input string sig, input issue_t got, input issue_t exp);
      checks++;
      if (got !== exp)
         note_error($sformatf("Fail %s exp 0x%h got 0x%h", sig, exp, got));
   endtask

   task automatic check_vld(input string sig, input logic got, input logic exp);
      checks++;
      if (got !== exp)
         note_error($sformatf("Fail %s exp 0x%h got 0x%h", sig, exp, got));
   endtask

   task automatic check_full(input logic got, input logic exp);
      checks++;
      if (got !== exp)
         note_error($sformatf("Fail full_o exp 0x%h got 0x%h", exp, got));
   endtask

   always @(posedge clk)
   begin
      model_step();
      started <= 1'b1;
   end

   // outputs settle after the edge, compare half a cycle later
   always @(negedge clk)
   begin
      if (started)
      begin
         check_full(full, exp_full);
         for (int p = 0; p < NUM_PORT; p++)
         begin
            check_vld($sformatf("%s_vld_o", port_name(p)), got_vld[p], exp_vld[p]);
            if (exp_vld[p])
               check_issue($sformatf("%s_iss_o", port_name(p)), got_iss[p], exp_iss[p]);
            if (got_vld[p] === 1'b1)
               issued++;
         end
      end
   end

   ////////////////////////////////////////
   // tests
   ////////////////////////////////////////

   initial
   begin
      alloc_t a;
      int     base;
      int     bb;
      clk = 1'b0;
      rst_n = 1'b0;
      started = 1'b0;
      lfsr_q = 16'd9593;
      alloc_vld = 1'b0;
      alloc = '0;
      flush = 1'b0;
      fu_rdy = '1;
      for (int b = 0; b < NUM_BCAST; b++)
         bcast[b] = '0;
      errors = 0;
      checks = 0;
      pushed = 0;
      issued = 0;
      test_no = 0;
      tests_failed = 0;
      err_base = 0;
      idle(2);
      rst_n = 1'b1;
      idle(2);

      for (int k = 0; k < 6; k++)
      begin
         a = make_inst(rand_class(), 1'b1, 1'b1);
         push(a);
         expect_issue(port_of(a.fu_class));
      end
      wait_drain();
      report_test("ready issue");

      // one wakeup per bus, then one at the allocation edge
      for (int b = 0; b < NUM_BCAST; b++)
      begin
         a = make_inst(rand_class(), 1'b0, 1'b1);
         push(a);
         idle(2);
         bcast[b] = {1'b1, a.psrc1};
         tick();
         bcast[b] = '0;
         expect_issue(port_of(a.fu_class));
      end
      a = make_inst(rand_class(), 1'b0, 1'b1);
      bb = int'(rand_bits(2));
      bcast[bb] = {1'b1, a.psrc1};
      push(a);
      bcast[bb] = '0;
      expect_issue(port_of(a.fu_class));
      wait_drain();
      report_test("wakeup");

      fu_rdy = '0;
      push(make_inst(FU_ALU, 1'b1, 1'b1));
      push(make_inst(FU_MUL, 1'b1, 1'b1));
      push(make_inst(FU_ALU, 1'b1, 1'b1));
      push(make_inst(FU_ADR, 1'b1, 1'b1));
      push(make_inst(FU_MUL, 1'b1, 1'b1));
      push(make_inst(FU_ALU, 1'b1, 1'b1));
      push(make_inst(FU_ADR, 1'b1, 1'b1));
      fu_rdy = '1;
      expect_issue(PORT_ALU0);
      check_vld("alu1_vld_o", got_vld[PORT_ALU1], 1'b1);
      check_vld("mul_vld_o", got_vld[PORT_MUL], 1'b1);
      check_vld("adr_vld_o", got_vld[PORT_ADR], 1'b1);
      wait_drain();
      report_test("priority");

      // fill, hold a ninth, free exactly one slot through alu 0
      fu_rdy = '0;
      for (int k = 0; k < ISQ_DEPTH; k++)
         push(make_inst(FU_ALU, 1'b1, 1'b1));
      check_full(full, 1'b1);
      a = make_inst(FU_ALU, 1'b1, 1'b1);
      alloc = a;
      alloc_vld = 1'b1;
      idle(3);
      check_full(full, 1'b1);
      fu_rdy[PORT_ALU0] = 1'b1;
      tick();
      fu_rdy = '0;
      check_full(full, 1'b0);
      push(a);
      check_full(full, 1'b1);
      report_test("full");

      fu_rdy[PORT_ALU1] = 1'b1;
      idle(3);
      check_vld("alu0_vld_o", got_vld[PORT_ALU0], 1'b0);
      fu_rdy = '1;
      wait_drain();
      report_test("back-pressure");

      fu_rdy = '0;
      for (int k = 0; k < ISQ_DEPTH; k++)
         push(make_inst(rand_class(), rand_bits(1) != 0, rand_bits(1) != 0));
      check_full(full, 1'b1);
      // flush wins over selection and allocation in the same cycle
      flush = 1'b1;
      fu_rdy = '1;
      alloc = make_inst(FU_ALU, 1'b1, 1'b1);
      alloc_vld = 1'b1;
      tick();
      flush = 1'b0;
      alloc_vld = 1'b0;
      check_full(full, 1'b0);
      base = issued;
      idle(8);
      if (issued != base)
         note_error("an entry from before the flush was issued");
      pushed = issued;
      report_test("flush");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_no, tests_failed, checks, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/is_cfg_pkg.sv
// sizing constants and vector types of the issue stage
// import into module bodies, use scoped names in port lists
`default_nettype none

package is_cfg_pkg;

   // queue, result bus and issue port counts
   localparam int ISQ_DEPTH = 8;
   localparam int NUM_BCAST = 4;
   localparam int NUM_PORT  = 4;
   localparam int PREG_W    = 6;

   // function unit port order
   localparam int PORT_MUL  = 0;
   localparam int PORT_ALU0 = 1;
   localparam int PORT_ALU1 = 2;
   localparam int PORT_ADR  = 3;

   typedef logic [PREG_W-1:0]    preg_t;
   typedef logic [ISQ_DEPTH-1:0] slot_vec_t;
   // valid in the top bit, tag below
   typedef logic [PREG_W:0]      bcast_t;

   // one-hot lowest set bit or zero if none
   function automatic slot_vec_t lowest_bit(input slot_vec_t v);
      return v & (~v + slot_vec_t'(1));
   endfunction

endpackage

`default_nettype wire

//--- verilog/is_inst_pkg.sv
// instruction formats seen by the issue stage
// alloc_t comes from allocation, issue_t leaves on each function unit port
`default_nettype none

package is_inst_pkg;

   typedef enum logic [1:0] {
      FU_MUL = 2'd0,
      FU_ALU = 2'd1,
      FU_ADR = 2'd2
   } fu_class_e;

   // opcode is not decoded here
   typedef logic [3:0] op_t;

   typedef struct packed {
      fu_class_e         fu_class;
      op_t               op;
      is_cfg_pkg::preg_t pdest;
      is_cfg_pkg::preg_t psrc1;
      logic              psrc1_rdy;
      is_cfg_pkg::preg_t psrc2;
      logic              psrc2_rdy;
   } alloc_t;

   typedef struct packed {
      op_t               op;
      is_cfg_pkg::preg_t pdest;
      is_cfg_pkg::preg_t psrc1;
      is_cfg_pkg::preg_t psrc2;
   } issue_t;

endpackage

`default_nettype wire

//--- verilog/is_queue.sv
// issue queue storage with one allocation per cycle
// writes the lowest free slot and flags full back to allocation
`default_nettype none

module is_queue (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                flush_i,
   input  logic                alloc_vld_i,
   input  is_inst_pkg::alloc_t alloc_i,
   output logic                full_o,
   isq_if.queue                q
);
   import is_cfg_pkg::*;
   import is_inst_pkg::*;

   slot_vec_t vld_q;
   slot_vec_t vld_d;
   slot_vec_t wr_en;
   logic      alloc_acc;

   // entry payload written on allocation only
   alloc_t ent_q [ISQ_DEPTH];

   ////////////////////////////////////////
   // allocation
   ////////////////////////////////////////

   // full only when every slot holds an entry
   assign full_o = &vld_q;

   // flush drops the incoming instruction
   assign alloc_acc = alloc_vld_i & ~full_o & ~flush_i;

   // slots cleared this edge stay busy until the next one
   assign wr_en = alloc_acc ? lowest_bit(~vld_q) : '0;

   always_ff @(posedge clk_i)
   begin
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         if (wr_en[i])
         begin
            ent_q[i] <= alloc_i;
         end
      end
   end

   ////////////////////////////////////////
   // valid bits
   ////////////////////////////////////////

   // issued slots drop out and the new one comes in
   assign vld_d = (vld_q & ~q.clr) | wr_en;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i || flush_i)
      begin
         vld_q <= '0;
      end
      else
      begin
         vld_q <= vld_d;
      end
   end

   // state seen by wakeup and select
   assign q.line_en  = wr_en;
   assign q.ent_vld  = vld_q;
   assign q.ent_data = ent_q;

endmodule

`default_nettype wire

//--- verilog/is_select.sv
// per-port selection of ready entries, lowest slot first
// issue words and valids are registered, chosen slots are cleared
`default_nettype none

module is_select (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  logic                            flush_i,
   input  logic [is_cfg_pkg::NUM_PORT-1:0] fu_rdy_i,
   output logic [is_cfg_pkg::NUM_PORT-1:0] iss_vld_o,
   output is_inst_pkg::issue_t             iss_o [is_cfg_pkg::NUM_PORT],
   isq_if.select                           s
);
   import is_cfg_pkg::*;
   import is_inst_pkg::*;

   slot_vec_t base;
   slot_vec_t cand_mul;
   slot_vec_t cand_alu;
   slot_vec_t cand_adr;
   slot_vec_t alu_first;
   slot_vec_t clr;
   slot_vec_t pick [NUM_PORT];
   issue_t    word [NUM_PORT];

   // drop class and ready flags for the register file
   function automatic issue_t to_issue(input alloc_t a);
      issue_t iw;
      iw.op    = a.op;
      iw.pdest = a.pdest;
      iw.psrc1 = a.psrc1;
      iw.psrc2 = a.psrc2;
      return iw;
   endfunction

   ////////////////////////////////////////
   // candidates and picks
   ////////////////////////////////////////

   assign base = s.ent_vld & s.src_rdy;

   always_comb
   begin
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         cand_mul[i] = base[i] && (s.ent_data[i].fu_class == FU_MUL);
         cand_alu[i] = base[i] && (s.ent_data[i].fu_class == FU_ALU);
         cand_adr[i] = base[i] && (s.ent_data[i].fu_class == FU_ADR);
      end
   end

   assign alu_first = lowest_bit(cand_alu);

   always_comb
   begin
      pick[PORT_MUL]  = lowest_bit(cand_mul);
      pick[PORT_ALU0] = alu_first;
      // second alu entry goes to alu 1
      pick[PORT_ALU1] = lowest_bit(cand_alu & ~alu_first);
      pick[PORT_ADR]  = lowest_bit(cand_adr);
      clr = '0;
      for (int p = 0; p < NUM_PORT; p++)
      begin
         // busy unit or flush, entry stays put
         if (!fu_rdy_i[p] || flush_i)
         begin
            pick[p] = '0;
         end
         clr |= pick[p];
         word[p] = '0;
         for (int i = 0; i < ISQ_DEPTH; i++)
         begin
            if (pick[p][i])
            begin
               word[p] = to_issue(s.ent_data[i]);
            end
         end
      end
   end

   assign s.clr = clr;

   ////////////////////////////////////////
   // issue registers
   ////////////////////////////////////////

   always_ff @(posedge clk_i)
   begin
      for (int p = 0; p < NUM_PORT; p++)
      begin
         if (!rst_n_i)
         begin
            iss_vld_o[p] <= 1'b0;
         end
         else
         begin
            iss_vld_o[p] <= |pick[p];
         end
         if (|pick[p])
         begin
            iss_o[p] <= word[p];
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/is_top.sv
// issue stage top, queue, wakeup and select joined by isq_if
// one allocation in, up to four issues out per cycle
`default_nettype none

module is_top (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  logic                            alloc_vld_i,
   input  is_inst_pkg::alloc_t             alloc_i,
   output logic                            full_o,
   input  logic                            flush_i,
   input  is_cfg_pkg::bcast_t              bcast_i [is_cfg_pkg::NUM_BCAST],
   input  logic [is_cfg_pkg::NUM_PORT-1:0] fu_rdy_i,
   output logic                            mul_vld_o,
   output is_inst_pkg::issue_t             mul_iss_o,
   output logic                            alu0_vld_o,
   output is_inst_pkg::issue_t             alu0_iss_o,
   output logic                            alu1_vld_o,
   output is_inst_pkg::issue_t             alu1_iss_o,
   output logic                            adr_vld_o,
   output is_inst_pkg::issue_t             adr_iss_o
);
   import is_cfg_pkg::*;
   import is_inst_pkg::*;

   logic [NUM_PORT-1:0] iss_vld;
   issue_t              iss [NUM_PORT];

   isq_if q_if ();

   is_queue u_queue (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .flush_i     (flush_i),
      .alloc_vld_i (alloc_vld_i),
      .alloc_i     (alloc_i),
      .full_o      (full_o),
      .q           (q_if)
   );

   is_wakeup u_wakeup (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .flush_i (flush_i),
      .alloc_i (alloc_i),
      .bcast_i (bcast_i),
      .w       (q_if)
   );

   is_select u_select (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .flush_i   (flush_i),
      .fu_rdy_i  (fu_rdy_i),
      .iss_vld_o (iss_vld),
      .iss_o     (iss),
      .s         (q_if)
   );

   // port vector split into named unit outputs
   assign mul_vld_o  = iss_vld[PORT_MUL];
   assign mul_iss_o  = iss[PORT_MUL];
   assign alu0_vld_o = iss_vld[PORT_ALU0];
   assign alu0_iss_o = iss[PORT_ALU0];
   assign alu1_vld_o = iss_vld[PORT_ALU1];
   assign alu1_iss_o = iss[PORT_ALU1];
   assign adr_vld_o  = iss_vld[PORT_ADR];
   assign adr_iss_o  = iss[PORT_ADR];

endmodule

`default_nettype wire

//--- verilog/is_wakeup.sv
// source operand ready tracking for each queue slot
// loads on allocation, then sets bits from result tag broadcasts
`default_nettype none

module is_wakeup (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                flush_i,
   input  is_inst_pkg::alloc_t alloc_i,
   input  is_cfg_pkg::bcast_t  bcast_i [is_cfg_pkg::NUM_BCAST],
   isq_if.wakeup               w
);
   import is_cfg_pkg::*;

   slot_vec_t rdy1_q;
   slot_vec_t rdy2_q;
   slot_vec_t hit1;
   slot_vec_t hit2;
   logic      alloc_hit1;
   logic      alloc_hit2;

   // tag matches a valid broadcast on any bus
   function automatic logic tag_hit(input preg_t tag, input bcast_t bc [NUM_BCAST]);
      logic hit;
      hit = 1'b0;
      for (int b = 0; b < NUM_BCAST; b++)
      begin
         hit |= bc[b][PREG_W] & (bc[b][PREG_W-1:0] == tag);
      end
      return hit;
   endfunction

   ////////////////////////////////////////
   // broadcast compare
   ////////////////////////////////////////

   always_comb
   begin
      // incoming instruction, not yet in storage
      alloc_hit1 = tag_hit(alloc_i.psrc1, bcast_i);
      alloc_hit2 = tag_hit(alloc_i.psrc2, bcast_i);
      for (int i = 0; i < ISQ_DEPTH; i++)
      begin
         hit1[i] = tag_hit(w.ent_data[i].psrc1, bcast_i);
         hit2[i] = tag_hit(w.ent_data[i].psrc2, bcast_i);
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i || flush_i)
      begin
         rdy1_q <= '0;
         rdy2_q <= '0;
      end
      else
      begin
         for (int i = 0; i < ISQ_DEPTH; i++)
         begin
            if (w.line_en[i])
            begin
               rdy1_q[i] <= alloc_i.psrc1_rdy | alloc_hit1;
               rdy2_q[i] <= alloc_i.psrc2_rdy | alloc_hit2;
            end
            else if (w.ent_vld[i])
            begin
               // sticky until the slot is reloaded
               rdy1_q[i] <= rdy1_q[i] | hit1[i];
               rdy2_q[i] <= rdy2_q[i] | hit2[i];
            end
         end
      end
   end

   assign w.src_rdy = rdy1_q & rdy2_q;

endmodule

`default_nettype wire

//--- verilog/isq_if.sv
// per-entry state shared by queue storage, wakeup and select
// one modport per block, flush is not carried here
`default_nettype none

interface isq_if;
   import is_cfg_pkg::*;
   import is_inst_pkg::*;

   // slot written this cycle, one-hot or zero
   slot_vec_t line_en;
   slot_vec_t ent_vld;
   alloc_t    ent_data [ISQ_DEPTH];
   // both sources ready
   slot_vec_t src_rdy;
   // slots issued this cycle
   slot_vec_t clr;

   modport queue (
      output line_en,
      output ent_vld,
      output ent_data,
      input  clr
   );

   modport wakeup (
      input  line_en,
      input  ent_vld,
      input  ent_data,
      output src_rdy
   );

   modport select (
      input  ent_vld,
      input  ent_data,
      input  src_rdy,
      output clr
   );

endinterface

`default_nettype wire
